//--- common/wts_consts.svh
// wavetable sound mixer constants
// slot timing, channel count, wave depth and word widths
`ifndef WTS_CONSTS_SVH
`define WTS_CONSTS_SVH

// ----------------------------------------
// slot sequencing
// ----------------------------------------
`define WTS_SLOTS       6   // slots per frame
`define WTS_CHANNELS    5   // voice channels per bank
`define WTS_CPU_SLOT    5   // host access to wave memory

// ----------------------------------------
// wave memory and datapath widths
// ----------------------------------------
`define WTS_WAVE_DEPTH  32  // samples per wave
`define WTS_FREQ_W      12  // frame reload width
`define WTS_MIX_W       12  // output word width

`endif

//--- common/wts_pkg.sv
// shared types for the two-bank wavetable sound mixer
`include "wts_consts.svh"

package wts_pkg;

	typedef logic [2:0] slot_t;                                  // slot, also channel index
	typedef logic [$clog2(`WTS_WAVE_DEPTH)-1:0] wave_addr_t;     // phase pointer
	typedef logic [7:0] ram_addr_t;                              // {channel, pointer}
	typedef logic signed [7:0] sample_t;
	typedef logic [3:0] volume_t;
	typedef logic [1:0] pan_t;                                   // [1] left, [0] right
	typedef logic [`WTS_FREQ_W-1:0] freq_t;
	typedef logic [`WTS_MIX_W-1:0] mix_t;

	// per-channel configuration
	typedef struct packed {
		volume_t volume;
		pan_t    pan;
		freq_t   freq;
	} chan_cfg_t;

	// host wave memory access, we/oe are one-cycle strobes
	typedef struct packed {
		logic       we;
		logic       oe;
		logic       bank;
		slot_t      chan;
		wave_addr_t addr;
		sample_t    data;
	} host_req_t;

	// one bank's contribution for a slot
	typedef struct packed {
		logic    valid;
		pan_t    pan;
		sample_t level;
	} voice_t;

endpackage

//--- dv/tb_wts.sv
// testbench for the two-bank wavetable sound mixer
// host access, key-on, pan gating and phase stepping
`include "wts_consts.svh"

module tb_wts;

	logic                                     clk = 1'b0;
	logic                                     nreset;
	wts_pkg::host_req_t                       host_req;
	logic [2*`WTS_CHANNELS-1:0]               key_on;
	wts_pkg::chan_cfg_t [2*`WTS_CHANNELS-1:0] cfg;
	wts_pkg::sample_t                         sram_q;
	logic                                     sram_q_en;
	wts_pkg::mix_t                            left_out;
	wts_pkg::mix_t                            right_out;
	logic                                     check_req;
	logic                                     silence_req;
	logic                                     track_en;
	int                                       steps;
	int                                       mismatches;
	int                                       proto_errs;
	int                                       timeouts;
	int                                       seed;

	wts_sound_top DUT (
		.clk       (clk),
		.nreset    (nreset),
		.host_req  (host_req),
		.key_on    (key_on),
		.cfg       (cfg),
		.sram_q    (sram_q),
		.sram_q_en (sram_q_en),
		.left_out  (left_out),
		.right_out (right_out)
	);

	wts_checker u_checker (
		.clk         (clk),
		.nreset      (nreset),
		.host_req    (host_req),
		.key_on      (key_on),
		.cfg         (cfg),
		.sram_q      (sram_q),
		.sram_q_en   (sram_q_en),
		.left_out    (left_out),
		.right_out   (right_out),
		.check_req   (check_req),
		.silence_req (silence_req),
		.track_en    (track_en),
		.steps       (steps),
		.mismatches  (mismatches),
		.proto_errs  (proto_errs)
	);

	initial begin
		forever #10 clk = ~clk;
	end

	// ----------------------------------------
	// stimulus tasks, called on a falling edge
	// ----------------------------------------
	task automatic host_strobe(logic we, int k, int a, wts_pkg::sample_t d);
		host_req.we   = we;
		host_req.oe   = ~we;
		host_req.bank = (k >= `WTS_CHANNELS);
		host_req.chan = wts_pkg::slot_t'(k % `WTS_CHANNELS);
		host_req.addr = wts_pkg::wave_addr_t'(a);
		host_req.data = d;
		@(negedge clk);
		host_req = '0;
	endtask

	task automatic host_write(int k, int a, wts_pkg::sample_t d);
		host_strobe(1'b1, k, a, d);
		repeat (7) @(negedge clk);   // write done 8 cycles after strobe
	endtask

	task automatic host_read(int k, int a);
		int n;
		host_strobe(1'b0, k, a, '0);
		n = 1;
		while (!sram_q_en && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (!sram_q_en) begin
			timeouts++;
			$display("ERROR time=%0t no sram_q_en pulse within 8 cycles of a read", $time);
		end
		@(negedge clk);
	endtask

	task automatic pulse_keys(logic [2*`WTS_CHANNELS-1:0] keys);
		key_on = keys;
		@(negedge clk);
		key_on = '0;
	endtask

	task automatic settle_and_check();
		repeat (3 * `WTS_SLOTS) @(negedge clk);   // three frames
		check_req = 1'b1;
		@(negedge clk);
		check_req = 1'b0;
	endtask

	task automatic wait_steps(int n);
		int target;
		int t;
		target = steps + n;
		t = 0;
		while (steps < target && t < n * 30) begin
			@(negedge clk);
			t++;
		end
		if (steps < target) begin
			timeouts++;
			$display("ERROR time=%0t left_out stopped stepping through the ramp", $time);
		end
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		int wk [12];
		int wa [12];
		seed = 94948;
		void'($urandom(seed));
		nreset = 1'b0;
		host_req = '0;
		key_on = '0;
		cfg = '0;
		check_req = 1'b0;
		silence_req = 1'b0;
		track_en = 1'b0;
		timeouts = 0;
		repeat (3) @(negedge clk);
		nreset = 1'b1;
		@(negedge clk);
		silence_req = 1'b1;   // outputs silent until the first full frame
		repeat (4) @(negedge clk);
		silence_req = 1'b0;
		for (int i = 0; i < 12; i++) begin
			wk[i] = $urandom % (2 * `WTS_CHANNELS);
			wa[i] = $urandom % `WTS_WAVE_DEPTH;
			host_write(wk[i], wa[i], wts_pkg::sample_t'($urandom));
		end
		for (int i = 0; i < 12; i++) begin
			host_read(wk[i], wa[i]);
		end
		for (int i = 0; i < 2*`WTS_CHANNELS; i++) begin
			cfg[i].pan = 2'b11;
			cfg[i].freq = 12'hfff;   // pointer parked at 0
		end
		pulse_keys('1);
		for (int r = 0; r < 4; r++) begin
			for (int i = 0; i < 2*`WTS_CHANNELS; i++) begin
				host_write(i, 0, wts_pkg::sample_t'($urandom));
				cfg[i].volume = wts_pkg::volume_t'($urandom);
			end
			settle_and_check();
		end
		for (int r = 0; r < 6; r++) begin
			for (int i = 0; i < 2*`WTS_CHANNELS; i++) begin
				cfg[i].pan = (r == 0) ? 2'b00 : (r == 1) ? 2'b11 : wts_pkg::pan_t'($urandom);
			end
			settle_and_check();
		end
		for (int i = 0; i < `WTS_WAVE_DEPTH; i++) begin
			host_write(0, i, wts_pkg::sample_t'(8 * i - 128));   // rising ramp
		end
		cfg[0].volume = 4'hf;
		cfg[0].pan = 2'b10;
		cfg[0].freq = 12'd1;
		settle_and_check();
		track_en = 1'b1;
		pulse_keys(10'b1);
		wait_steps(40);   // through the wrap
		pulse_keys(10'b1);
		wait_steps(4);
		track_en = 1'b0;
		repeat (2) @(negedge clk);
		$display("error counts: mismatches=%0d protocol=%0d timeouts=%0d",
			mismatches, proto_errs, timeouts);
		if (mismatches + proto_errs + timeouts == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- dv/wts_checker.sv
// checker for the wavetable mixer
// shadows host writes and key-on, compares outputs with a reference mix
`include "wts_consts.svh"

module wts_checker (
	input  logic                                     clk,
	input  logic                                     nreset,
	input  wts_pkg::host_req_t                       host_req,
	input  logic [2*`WTS_CHANNELS-1:0]               key_on,
	input  wts_pkg::chan_cfg_t [2*`WTS_CHANNELS-1:0] cfg,
	input  wts_pkg::sample_t                         sram_q,
	input  logic                                     sram_q_en,
	input  wts_pkg::mix_t                            left_out,
	input  wts_pkg::mix_t                            right_out,
	input  logic                                     check_req,
	input  logic                                     silence_req,
	input  logic                                     track_en,   // follow the key 0 ramp
	output int                                       steps,
	output int                                       mismatches,
	output int                                       proto_errs
);

	wts_pkg::sample_t shadow [2*`WTS_CHANNELS][`WTS_WAVE_DEPTH];   // by key index
	int               model_ptr [2*`WTS_CHANNELS];
	wts_pkg::sample_t exp_q;
	wts_pkg::mix_t    prev_left;
	logic             read_pend;
	logic             restart_pend;   // key-on seen mid-ramp

	initial begin
		steps = 0;
		mismatches = 0;
		proto_errs = 0;
		read_pend = 1'b0;
		restart_pend = 1'b0;
		for (int k = 0; k < 2*`WTS_CHANNELS; k++) begin
			model_ptr[k] = 0;
		end
	end

	// frame sum of one side (1 left, 0 right) in offset binary
	function automatic wts_pkg::mix_t expected_mix(int side);
		int sum;
		int level;
		sum = 0;
		for (int k = 0; k < 2*`WTS_CHANNELS; k++) begin
			level = (int'(shadow[k][model_ptr[k]]) * int'(cfg[k].volume)) >>> 4;
			if (cfg[k].pan[side]) begin
				sum += level;
			end
		end
		return wts_pkg::mix_t'(sum + 2048);
	endfunction

	task automatic compare_word(string name, wts_pkg::mix_t exp, wts_pkg::mix_t act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
		end
	endtask

	// ----------------------------------------
	// sampling and comparison
	// ----------------------------------------
	always @(posedge clk) begin
		if (nreset) begin
			if (sram_q_en && !read_pend) begin
				proto_errs++;
				$display("ERROR time=%0t sram_q_en pulsed with no read pending", $time);
			end else if (sram_q_en && sram_q !== exp_q) begin
				mismatches++;
				$display("MISMATCH time=%0t signal=sram_q expected=%h actual=%h",
					$time, exp_q, sram_q);
			end
			if (sram_q_en) begin
				read_pend = 1'b0;
			end
			if (host_req.we) begin
				shadow[host_req.bank * `WTS_CHANNELS + host_req.chan][host_req.addr] = host_req.data;
			end
			if (host_req.oe) begin
				exp_q = shadow[host_req.bank * `WTS_CHANNELS + host_req.chan][host_req.addr];
				read_pend = 1'b1;
			end
			if (track_en && left_out !== prev_left) begin   // next distinct ramp value
				model_ptr[0] = restart_pend ? 0 : (model_ptr[0] + 1) % `WTS_WAVE_DEPTH;
				restart_pend = 1'b0;
				compare_word("left_out", expected_mix(1), left_out);
				steps++;
			end
			for (int k = 0; k < 2*`WTS_CHANNELS; k++) begin
				if (key_on[k] && track_en && k == 0) begin
					restart_pend = (model_ptr[0] != 0);   // at 0 already, no visible restart
				end else if (key_on[k]) begin
					model_ptr[k] = 0;
				end
			end
			if (check_req) begin
				compare_word("left_out", expected_mix(1), left_out);
				compare_word("right_out", expected_mix(0), right_out);
			end
			if (silence_req) begin
				compare_word("left_out", 12'h800, left_out);
				compare_word("right_out", 12'h800, right_out);
			end
		end
		prev_left = left_out;
	end

endmodule

//--- logic/wts_slot_sequencer.sv
// slot sequencer, six slots per frame
// holds a pending host access until slot 5 and flags read data
`include "wts_consts.svh"

module wts_slot_sequencer (
	input  logic               clk,
	input  logic               nreset,
	input  wts_pkg::host_req_t host_req,
	output wts_pkg::slot_t     slot,
	output wts_pkg::host_req_t access,
	output logic               sram_q_en,
	output logic               q_bank
);

	wts_pkg::host_req_t req_q;   // captured address and data
	logic pend_we;
	logic pend_oe;
	logic strobe;
	logic cpu_slot;

	assign strobe   = host_req.we | host_req.oe;
	assign cpu_slot = (slot == wts_pkg::slot_t'(`WTS_CPU_SLOT));

	// ----------------------------------------
	// slot counter
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			slot <= '0;
		end else if (slot == wts_pkg::slot_t'(`WTS_SLOTS - 1)) begin
			slot <= '0;
		end else begin
			slot <= slot + 1'b1;
		end
	end

	// ----------------------------------------
	// pending host access
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			pend_we <= 1'b0;
			pend_oe <= 1'b0;
		end else if (strobe) begin
			pend_we <= host_req.we;
			pend_oe <= host_req.oe;
		end else if (cpu_slot) begin   // access done this slot
			pend_we <= 1'b0;
			pend_oe <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (strobe) begin
			req_q <= host_req;
		end
	end

	always_comb begin
		access    = req_q;
		access.we = pend_we;
		access.oe = pend_oe;
	end

	// read data valid one cycle after the ram is read
	always_ff @(posedge clk) begin
		if (!nreset) begin
			sram_q_en <= 1'b0;
			q_bank    <= 1'b0;
		end else begin
			sram_q_en <= cpu_slot & pend_oe;
			if (cpu_slot && pend_oe) begin
				q_bank <= req_q.bank;
			end
		end
	end

	// one access in flight at a time
	a_no_overlap: assert property (@(posedge clk) disable iff (!nreset)
		(pend_we | pend_oe) |-> !strobe);

	a_we_oe_excl: assert property (@(posedge clk) disable iff (!nreset)
		!(host_req.we && host_req.oe));

endmodule

//--- logic/wts_sound_top.sv
// two-bank wavetable sound mixer, top level
// sequencer, two voice banks and the stereo mixer
`include "wts_consts.svh"

module wts_sound_top (
	input  logic                                      clk,
	input  logic                                      nreset,
	input  wts_pkg::host_req_t                        host_req,
	input  logic [2*`WTS_CHANNELS-1:0]                key_on,    // bank * 5 + channel
	input  wts_pkg::chan_cfg_t [2*`WTS_CHANNELS-1:0]  cfg,
	output wts_pkg::sample_t                          sram_q,
	output logic                                      sram_q_en,
	output wts_pkg::mix_t                             left_out,
	output wts_pkg::mix_t                             right_out
);

	wts_pkg::slot_t     slot;
	wts_pkg::host_req_t access;
	logic               q_bank;
	wts_pkg::voice_t    voice0;
	wts_pkg::voice_t    voice1;
	wts_pkg::sample_t   rdata0;
	wts_pkg::sample_t   rdata1;

	wts_slot_sequencer u_seq (
		.clk       (clk),
		.nreset    (nreset),
		.host_req  (host_req),
		.slot      (slot),
		.access    (access),
		.sram_q_en (sram_q_en),
		.q_bank    (q_bank)
	);

	wts_voice_bank u_bank0 (
		.clk     (clk),
		.nreset  (nreset),
		.bank_id (1'b0),
		.slot    (slot),
		.access  (access),
		.key_on  (key_on[`WTS_CHANNELS-1:0]),
		.cfg     (cfg[`WTS_CHANNELS-1:0]),
		.voice   (voice0),
		.rdata   (rdata0)
	);

	wts_voice_bank u_bank1 (
		.clk     (clk),
		.nreset  (nreset),
		.bank_id (1'b1),
		.slot    (slot),
		.access  (access),
		.key_on  (key_on[2*`WTS_CHANNELS-1:`WTS_CHANNELS]),
		.cfg     (cfg[2*`WTS_CHANNELS-1:`WTS_CHANNELS]),
		.voice   (voice1),
		.rdata   (rdata1)
	);

	assign sram_q = q_bank ? rdata1 : rdata0;   // bank of the last read

	wts_stereo_mixer u_mixer (
		.clk       (clk),
		.nreset    (nreset),
		.slot      (slot),
		.voice0    (voice0),
		.voice1    (voice1),
		.left_out  (left_out),
		.right_out (right_out)
	);

endmodule

//--- logic/wts_stereo_mixer.sv
// stereo mixer, pan gating of both banks
// accumulates one frame, offset-binary outputs
`include "wts_consts.svh"

module wts_stereo_mixer (
	input  logic            clk,
	input  logic            nreset,
	input  wts_pkg::slot_t  slot,
	input  wts_pkg::voice_t voice0,
	input  wts_pkg::voice_t voice1,
	output wts_pkg::mix_t   left_out,
	output wts_pkg::mix_t   right_out
);

	// last channel reaches the mixer two slots after its address slot
	localparam int LAST_SLOT = (`WTS_CHANNELS + 1) % `WTS_SLOTS;

	wts_pkg::mix_t acc_l;
	wts_pkg::mix_t acc_r;
	wts_pkg::mix_t sum_l;
	wts_pkg::mix_t sum_r;
	logic          frame_end;

	// sign-extend a voice, zero unless valid and panned to this side
	function automatic wts_pkg::mix_t gate(wts_pkg::voice_t v, int side);
		wts_pkg::mix_t ext;
		ext = {{(`WTS_MIX_W - 8){v.level[7]}}, v.level};
		return (v.valid && v.pan[side]) ? ext : '0;
	endfunction

	assign sum_l = acc_l + gate(voice0, 1) + gate(voice1, 1);
	assign sum_r = acc_r + gate(voice0, 0) + gate(voice1, 0);

	assign frame_end = (slot == wts_pkg::slot_t'(LAST_SLOT));

	// ----------------------------------------
	// frame accumulation
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			acc_l <= '0;
			acc_r <= '0;
		end else if (frame_end) begin
			acc_l <= '0;   // restart for next frame
			acc_r <= '0;
		end else begin
			acc_l <= sum_l;
			acc_r <= sum_r;
		end
	end

	// two's complement to offset binary
	always_ff @(posedge clk) begin
		if (!nreset) begin
			left_out  <= 12'h800;   // silence
			right_out <= 12'h800;
		end else if (frame_end) begin
			left_out  <= {~sum_l[`WTS_MIX_W-1], sum_l[`WTS_MIX_W-2:0]};
			right_out <= {~sum_r[`WTS_MIX_W-1], sum_r[`WTS_MIX_W-2:0]};
		end
	end

endmodule

//--- sim.f
+incdir+common
common/wts_pkg.sv
logic/wts_slot_sequencer.sv
voice_bank/wts_phase_generator.sv
voice_bank/wts_wave_ram.sv
voice_bank/wts_voice_bank.sv
logic/wts_stereo_mixer.sv
logic/wts_sound_top.sv
dv/wts_checker.sv
dv/tb_wts.sv

//--- voice_bank/wts_phase_generator.sv
// phase generator for the five channels of a bank
// frame counters, wave pointers and key-on restart
`include "wts_consts.svh"

module wts_phase_generator (
	input  logic                                clk,
	input  logic                                nreset,
	input  wts_pkg::slot_t                      slot,
	input  logic [`WTS_CHANNELS-1:0]            key_on,
	input  wts_pkg::freq_t [`WTS_CHANNELS-1:0]  freq,
	output wts_pkg::wave_addr_t                 pointer
);

	wts_pkg::wave_addr_t ptr [`WTS_CHANNELS];
	wts_pkg::freq_t cnt [`WTS_CHANNELS];      // frames left until next step
	logic [`WTS_CHANNELS-1:0] key_pend;
	logic [`WTS_CHANNELS-1:0] kick;           // restart requested
	logic [`WTS_CHANNELS-1:0] active;         // channel owns this slot

	always_comb begin
		for (int i = 0; i < `WTS_CHANNELS; i++) begin
			active[i] = (slot == wts_pkg::slot_t'(i));
			kick[i]   = key_pend[i] | key_on[i];
		end
	end

	// ----------------------------------------
	// per-channel state update
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			key_pend <= '0;
			for (int i = 0; i < `WTS_CHANNELS; i++) begin
				ptr[i] <= '0;
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `WTS_CHANNELS; i++) begin
				if (active[i]) begin
					key_pend[i] <= 1'b0;
					if (kick[i]) begin
						ptr[i] <= '0;
						cnt[i] <= freq[i];
					end else if (cnt[i] == '0) begin
						ptr[i] <= ptr[i] + 1'b1;   // wraps at wave end
						cnt[i] <= freq[i];
					end else begin
						cnt[i] <= cnt[i] - 1'b1;
					end
				end else if (key_on[i]) begin
					key_pend[i] <= 1'b1;   // held until the channel slot
				end
			end
		end
	end

	// pointer for the channel of this slot
	always_comb begin
		pointer = '0;
		for (int i = 0; i < `WTS_CHANNELS; i++) begin
			if (active[i]) begin
				pointer = kick[i] ? '0 : ptr[i];
			end
		end
	end

endmodule

//--- voice_bank/wts_voice_bank.sv
// one voice bank with wave ram, phase generator and volume scaling
// slots 0 to 4 play channels and slot 5 serves the host
`include "wts_consts.svh"

module wts_voice_bank (
	input  logic                                  clk,
	input  logic                                  nreset,
	input  logic                                  bank_id,   // tied to 0 or 1 at the top
	input  wts_pkg::slot_t                        slot,
	input  wts_pkg::host_req_t                    access,
	input  logic [`WTS_CHANNELS-1:0]              key_on,
	input  wts_pkg::chan_cfg_t [`WTS_CHANNELS-1:0] cfg,
	output wts_pkg::voice_t                       voice,
	output wts_pkg::sample_t                      rdata
);

	wts_pkg::freq_t [`WTS_CHANNELS-1:0] freq;
	wts_pkg::wave_addr_t pointer;
	wts_pkg::ram_addr_t  ram_addr;
	wts_pkg::sample_t    sample;
	wts_pkg::chan_cfg_t  sel_cfg;
	logic                cpu_slot;
	logic                ram_we;
	logic                s1_valid;   // stage aligned with ram output
	wts_pkg::volume_t    s1_volume;
	wts_pkg::pan_t       s1_pan;
	logic signed [12:0]  product;

	always_comb begin
		for (int i = 0; i < `WTS_CHANNELS; i++) begin
			freq[i] = cfg[i].freq;
		end
	end

	wts_phase_generator u_phase (
		.clk     (clk),
		.nreset  (nreset),
		.slot    (slot),
		.key_on  (key_on),
		.freq    (freq),
		.pointer (pointer)
	);

	// ----------------------------------------
	// ram address and write select
	// ----------------------------------------
	assign cpu_slot = (slot == wts_pkg::slot_t'(`WTS_CPU_SLOT));
	assign ram_addr = cpu_slot ? {access.chan, access.addr} : {slot, pointer};
	assign ram_we   = cpu_slot & access.we & (access.bank == bank_id);

	wts_wave_ram u_ram (
		.clk  (clk),
		.we   (ram_we),
		.addr (ram_addr),
		.d    (access.data),
		.q    (sample)
	);

	assign rdata = sample;

	// ----------------------------------------
	// volume scaling
	// ----------------------------------------
	assign sel_cfg = cpu_slot ? '0 : cfg[slot];

	always_ff @(posedge clk) begin
		s1_volume <= sel_cfg.volume;
		s1_pan    <= sel_cfg.pan;
		if (!nreset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= ~cpu_slot;
		end
	end

	assign product = sample * $signed({1'b0, s1_volume});

	always_ff @(posedge clk) begin
		voice.pan   <= s1_pan;
		voice.level <= product[11:4];   // sample * volume >>> 4
		if (!nreset) begin
			voice.valid <= 1'b0;
		end else begin
			voice.valid <= s1_valid;
		end
	end

	// host slot result lands in slot 1 and never reaches the mixer
	a_host_slot_silent: assert property (@(posedge clk) disable iff (!nreset)
		(slot == wts_pkg::slot_t'(1)) |-> !voice.valid);

endmodule

//--- voice_bank/wts_wave_ram.sv
// wave memory for one bank
// 5 channels x 32 samples, synchronous read and write
`include "wts_consts.svh"

module wts_wave_ram (
	input  logic               clk,
	input  logic               we,
	input  wts_pkg::ram_addr_t addr,
	input  wts_pkg::sample_t   d,
	output wts_pkg::sample_t   q
);

	localparam int DEPTH = `WTS_CHANNELS * `WTS_WAVE_DEPTH;

	wts_pkg::sample_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we && addr < wts_pkg::ram_addr_t'(DEPTH)) begin
			mem[addr] <= d;
		end
		q <= mem[addr];   // read before write
	end

endmodule
